/* files.f */
rtl/cu_pkg.sv
rtl/cmd_queue_if.sv
rtl/cmd_fifo.sv
rtl/job_requester.sv
rtl/read_cmd_arbiter.sv
rtl/response_router.sv
rtl/cu_control.sv
tests/cu_control_sva.sv
tests/cu_control_tb.sv

/* rtl/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo import cu_pkg::*; #(
	parameter int DEPTH    = 8,
	parameter int HEADROOM = 4
) (
	input  logic      clock,
	input  logic      rstn,
	input  logic      push,
	input  read_cmd_t data_in,
	input  logic      pop,
	output read_cmd_t data_out,
	output logic      empty,
	output logic      full,
	output logic      alfull
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	read_cmd_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Head word is visible before the pop
	assign data_out = mem[rd_ptr];

	assign empty  = (count == '0);
	assign full   = (count == CNT_W'(DEPTH));
	// Fewer than HEADROOM free slots left
	assign alfull = (count > CNT_W'(DEPTH - HEADROOM));

endmodule

`default_nettype wire

/* rtl/cmd_queue_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Head of a requester command queue as seen by the arbiter.
// Data is shown first word fall through, pop consumes it at the edge.
interface cmd_queue_if import cu_pkg::*; ();

	// Command at the head of the queue
	read_cmd_t cmd;

	// No command waiting
	logic empty;

	// Take the head command, only while empty is low
	logic pop;

	// Requester side
	modport queue (
		output cmd,
		output empty,
		input  pop
	);

	// Arbiter side
	modport grant (
		input  cmd,
		input  empty,
		output pop
	);

endinterface

`default_nettype wire

/* rtl/cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control import cu_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int BURST_DEPTH = 16,
	parameter int HEADROOM    = 4,
	parameter int CHUNK_SIZE  = 16
) (
	input  logic      clock,
	input  logic      rstn,
	input  logic      enabled_in,
	input  logic      start,
	input  count_t    num_vertices,
	input  count_t    num_edges,
	input  logic      read_alfull,
	input  logic      read_rsp_valid,
	input  cu_id_t    read_rsp_cu_id,
	input  chunk_t    read_rsp_count,
	output logic      read_cmd_valid,
	output cu_id_t    read_cmd_cu_id,
	output cmd_kind_t read_cmd_kind,
	output count_t    read_cmd_index,
	output chunk_t    read_cmd_count,
	output logic      cu_done,
	output count_t    cu_return
);

	logic      enabled;
	logic      job_start;
	logic      job_active;
	count_t    total_vertices;
	count_t    total_edges;
	count_t    vertex_done;
	count_t    edge_done;
	logic      done_now;
	logic      vertex_rsp;
	logic      edge_rsp;
	chunk_t    routed_count;
	read_cmd_t cmd_out;

	cmd_queue_if vertex_q ();
	cmd_queue_if edge_q ();

	//////////////////////////////////////////////////
	// Enable and job latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	assign job_start = enabled && start;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_active     <= 1'b0;
			total_vertices <= '0;
			total_edges    <= '0;
		end else if (job_start) begin
			job_active     <= 1'b1;
			total_vertices <= num_vertices;
			total_edges    <= num_edges;
		end
	end

	//////////////////////////////////////////////////
	// Done and return value
	//////////////////////////////////////////////////

	assign done_now = job_active && (vertex_done == total_vertices) && (edge_done == total_edges);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
		end else if (job_start) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
		end else if (enabled) begin
			cu_done <= done_now;
			if (done_now)
				cu_return <= vertex_done;
		end
	end

	//////////////////////////////////////////////////
	// Requesters, arbiter and response path
	//////////////////////////////////////////////////

	job_requester #(
		.OWNER(CU_VERTEX), .QUEUE_DEPTH(QUEUE_DEPTH), .HEADROOM(HEADROOM), .CHUNK_SIZE(CHUNK_SIZE)
	) u_vertex_req (
		.clock(clock), .rstn(rstn), .enabled(enabled), .job_start(job_start),
		.total(total_vertices), .rsp_valid(vertex_rsp), .rsp_count(routed_count),
		.done_count(vertex_done), .q(vertex_q)
	);

	job_requester #(
		.OWNER(CU_EDGE), .QUEUE_DEPTH(QUEUE_DEPTH), .HEADROOM(HEADROOM), .CHUNK_SIZE(CHUNK_SIZE)
	) u_edge_req (
		.clock(clock), .rstn(rstn), .enabled(enabled), .job_start(job_start),
		.total(total_edges), .rsp_valid(edge_rsp), .rsp_count(routed_count),
		.done_count(edge_done), .q(edge_q)
	);

	read_cmd_arbiter #(.BURST_DEPTH(BURST_DEPTH), .HEADROOM(HEADROOM)) u_arbiter (
		.clock(clock), .rstn(rstn), .enabled(enabled), .read_alfull(read_alfull),
		.vq(vertex_q), .eq(edge_q), .cmd_valid(read_cmd_valid), .cmd_out(cmd_out)
	);

	response_router u_router (
		.clock(clock), .rstn(rstn), .enabled(enabled), .rsp_valid(read_rsp_valid),
		.rsp_cu_id(read_rsp_cu_id), .rsp_count(read_rsp_count),
		.vertex_valid(vertex_rsp), .edge_valid(edge_rsp), .routed_count(routed_count)
	);

	// Memory port fields
	assign read_cmd_cu_id = cmd_out.cu_id;
	assign read_cmd_kind  = cmd_out.kind;
	assign read_cmd_index = cmd_out.index;
	assign read_cmd_count = cmd_out.count;

endmodule

`default_nettype wire

/* rtl/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Item counts and array indices
	localparam int COUNT_W = 32;

	// Items carried by one read command
	localparam int CHUNK_W = 8;

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [CHUNK_W-1:0] chunk_t;

	//////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////

	// Owner of a command, and of the response that comes back for it
	typedef enum logic [0:0] {
		CU_VERTEX = 1'b0,
		CU_EDGE   = 1'b1
	} cu_id_t;

	// Which array a read command walks
	typedef enum logic [0:0] {
		READ_VERTEX = 1'b0,
		READ_EDGE   = 1'b1
	} cmd_kind_t;

	//////////////////////////////////////////////////
	// Read command
	//////////////////////////////////////////////////

	typedef struct packed {
		cu_id_t    cu_id;
		cmd_kind_t kind;
		count_t    index;
		chunk_t    count;
	} read_cmd_t;

endpackage

`default_nettype wire

/* rtl/job_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module job_requester import cu_pkg::*; #(
	parameter cu_id_t OWNER       = CU_VERTEX,
	parameter int     QUEUE_DEPTH = 8,
	parameter int     HEADROOM    = 4,
	parameter int     CHUNK_SIZE  = 16
) (
	input  logic   clock,
	input  logic   rstn,
	input  logic   enabled,
	input  logic   job_start,
	input  count_t total,
	input  logic   rsp_valid,
	input  chunk_t rsp_count,
	output count_t done_count,
	cmd_queue_if.queue q
);

	localparam cmd_kind_t KIND = (OWNER == CU_VERTEX) ? READ_VERTEX : READ_EDGE;

	count_t    issue_ptr;
	count_t    remaining;
	chunk_t    chunk;
	read_cmd_t cmd_next;
	logic      cmd_push;
	logic      q_full;
	logic      q_alfull;

	//////////////////////////////////////////////////
	// Command split
	//////////////////////////////////////////////////

	assign remaining = total - issue_ptr;

	always_comb begin
		if (remaining > count_t'(CHUNK_SIZE))
			chunk = chunk_t'(CHUNK_SIZE);
		else
			chunk = remaining[CHUNK_W-1:0];
		cmd_next.cu_id = OWNER;
		cmd_next.kind  = KIND;
		cmd_next.index = issue_ptr;
		cmd_next.count = chunk;
	end

	// Hold off during the start edge, the totals are still changing
	assign cmd_push = enabled && !job_start && (issue_ptr < total) && !q_alfull && !q_full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_ptr <= '0;
		end else if (job_start) begin
			issue_ptr <= '0;
		end else if (cmd_push) begin
			issue_ptr <= issue_ptr + count_t'(chunk);
		end
	end

	//////////////////////////////////////////////////
	// Completed items
	//////////////////////////////////////////////////

	// The router only accepts responses while enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_count <= '0;
		end else if (job_start) begin
			done_count <= '0;
		end else if (rsp_valid) begin
			done_count <= done_count + count_t'(rsp_count);
		end
	end

	cmd_fifo #(
		.DEPTH   (QUEUE_DEPTH),
		.HEADROOM(HEADROOM)
	) u_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in (cmd_next),
		.pop     (q.pop),
		.data_out(q.cmd),
		.empty   (q.empty),
		.full    (q_full),
		.alfull  (q_alfull)
	);

endmodule

`default_nettype wire

/* rtl/read_cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_cmd_arbiter import cu_pkg::*; #(
	parameter int BURST_DEPTH = 16,
	parameter int HEADROOM    = 4
) (
	input  logic      clock,
	input  logic      rstn,
	input  logic      enabled,
	input  logic      read_alfull,
	cmd_queue_if.grant vq,
	cmd_queue_if.grant eq,
	output logic      cmd_valid,
	output read_cmd_t cmd_out
);

	cu_id_t    prio;
	logic      can_grant;
	logic      grant_v;
	logic      grant_e;
	read_cmd_t burst_in;
	read_cmd_t burst_out;
	logic      burst_pop;
	logic      burst_empty;
	logic      burst_full;
	logic      burst_alfull;

	//////////////////////////////////////////////////
	// Round robin grant
	//////////////////////////////////////////////////

	assign can_grant = enabled && !read_alfull && !burst_alfull && !burst_full;

	// prio names the queue that wins when both are waiting
	assign grant_v = can_grant && !vq.empty && (eq.empty || prio == CU_VERTEX);
	assign grant_e = can_grant && !eq.empty && (vq.empty || prio == CU_EDGE);

	assign vq.pop  = grant_v;
	assign eq.pop  = grant_e;
	assign burst_in = grant_v ? vq.cmd : eq.cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			prio <= CU_VERTEX;
		else if (grant_v)
			prio <= CU_EDGE;
		else if (grant_e)
			prio <= CU_VERTEX;
	end

	//////////////////////////////////////////////////
	// Burst buffer and memory port
	//////////////////////////////////////////////////

	assign burst_pop = enabled && !burst_empty && !read_alfull;

	cmd_fifo #(
		.DEPTH   (BURST_DEPTH),
		.HEADROOM(HEADROOM)
	) u_burst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (grant_v || grant_e),
		.data_in (burst_in),
		.pop     (burst_pop),
		.data_out(burst_out),
		.empty   (burst_empty),
		.full    (burst_full),
		.alfull  (burst_alfull)
	);

	// Strobe, so it drops as soon as the pop stops
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= burst_pop;
	end

	always_ff @(posedge clock) begin
		if (burst_pop)
			cmd_out <= burst_out;
	end

endmodule

`default_nettype wire

/* rtl/response_router.sv */
`timescale 1ns/1ps
`default_nettype none

module response_router import cu_pkg::*; (
	input  logic   clock,
	input  logic   rstn,
	input  logic   enabled,
	input  logic   rsp_valid,
	input  cu_id_t rsp_cu_id,
	input  chunk_t rsp_count,
	output logic   vertex_valid,
	output logic   edge_valid,
	output chunk_t routed_count
);

	logic   rsp_valid_q;
	cu_id_t rsp_cu_id_q;
	chunk_t rsp_count_q;

	// Input stage, responses are taken only while enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= enabled && rsp_valid;
	end

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			rsp_cu_id_q <= rsp_cu_id;
			rsp_count_q <= rsp_count;
		end
	end

	// One strobe per latched response, picked by owner
	assign vertex_valid = rsp_valid_q && (rsp_cu_id_q == CU_VERTEX);
	assign edge_valid   = rsp_valid_q && (rsp_cu_id_q == CU_EDGE);
	assign routed_count = rsp_count_q;

endmodule

`default_nettype wire

/* tests/cu_control_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_sva (
	input logic clock,
	input logic rstn,
	input logic job_start,
	input logic read_alfull,
	input logic read_cmd_valid,
	input logic cu_done,
	input logic vertex_rsp,
	input logic edge_rsp,
	input logic vertex_pop,
	input logic vertex_empty,
	input logic edge_pop,
	input logic edge_empty
);

	int   failures = 0;
	logic seen_start;

	// Set by the first accepted start
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			seen_start <= 1'b0;
		else if (job_start)
			seen_start <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Response routing and queue pops
	//////////////////////////////////////////////////

	a_one_route: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_rsp && edge_rsp))
		else begin
			failures++;
			$error("Vertex and edge response strobes high together");
		end

	a_vertex_pop: assert property (@(posedge clock) disable iff (!rstn)
		vertex_pop |-> !vertex_empty)
		else begin
			failures++;
			$error("Pop on an empty vertex queue");
		end

	a_edge_pop: assert property (@(posedge clock) disable iff (!rstn)
		edge_pop |-> !edge_empty)
		else begin
			failures++;
			$error("Pop on an empty edge queue");
		end

	//////////////////////////////////////////////////
	// Memory port
	//////////////////////////////////////////////////

	a_valid_after_room: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> $past(!read_alfull))
		else begin
			failures++;
			$error("Read command issued after read_alfull was high");
		end

	// Quiet outputs until the first job
	a_idle_after_reset: assert property (@(posedge clock) disable iff (!rstn)
		!seen_start |-> (!read_cmd_valid && !cu_done))
		else begin
			failures++;
			$error("Output activity before the first start");
		end

endmodule

`default_nettype wire

/* tests/cu_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_tb import cu_pkg::*; ();

	localparam int CHUNK_SIZE = 16;
	localparam int NUM_JOBS   = 6;

	logic        clock;
	logic        rstn;
	logic        enabled_in;
	logic        start;
	count_t      num_vertices;
	count_t      num_edges;
	logic        read_alfull;
	logic        read_rsp_valid;
	cu_id_t      read_rsp_cu_id;
	chunk_t      read_rsp_count;
	logic        read_cmd_valid;
	cu_id_t      read_cmd_cu_id;
	cmd_kind_t   read_cmd_kind;
	count_t      read_cmd_index;
	chunk_t      read_cmd_count;
	logic        cu_done;
	count_t      cu_return;

	// Expected command sequence per owner
	read_cmd_t   exp_vertex [$];
	read_cmd_t   exp_edge [$];
	// Responses waiting in the memory model
	int          pend_due [$];
	cu_id_t      pend_id [$];
	chunk_t      pend_cnt [$];

	count_t      job_nv [NUM_JOBS];
	count_t      job_ne [NUM_JOBS];
	count_t      vertex_items;
	count_t      edge_items;
	int          cycle = 0;
	int          cycle_limit = 0;
	int          low_cycles = 0;
	bit          job_running = 1'b0;
	bit          done_seen = 1'b0;
	int          cmd_errors = 0;
	int          count_errors = 0;
	int          other_errors = 0;

	cu_control #(.CHUNK_SIZE(CHUNK_SIZE)) u_cu_control (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in), .start(start),
		.num_vertices(num_vertices), .num_edges(num_edges), .read_alfull(read_alfull),
		.read_rsp_valid(read_rsp_valid), .read_rsp_cu_id(read_rsp_cu_id),
		.read_rsp_count(read_rsp_count), .read_cmd_valid(read_cmd_valid),
		.read_cmd_cu_id(read_cmd_cu_id), .read_cmd_kind(read_cmd_kind),
		.read_cmd_index(read_cmd_index), .read_cmd_count(read_cmd_count),
		.cu_done(cu_done), .cu_return(cu_return)
	);

	bind cu_control cu_control_sva u_cu_control_sva (
		.clock(clock), .rstn(rstn), .job_start(job_start), .read_alfull(read_alfull),
		.read_cmd_valid(read_cmd_valid), .cu_done(cu_done),
		.vertex_rsp(vertex_rsp), .edge_rsp(edge_rsp),
		.vertex_pop(vertex_q.pop), .vertex_empty(vertex_q.empty),
		.edge_pop(edge_q.pop), .edge_empty(edge_q.empty)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		if (cycle_limit != 0 && cycle > cycle_limit) begin
			$display("Timeout: no finish within %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic check_cmd(input string name, input read_cmd_t expected,
		input read_cmd_t actual);
		if (actual !== expected) begin
			cmd_errors++;
			$display("error %s: expected id %0d kind %0d index %0d count %0d, %s",
				name, expected.cu_id, expected.kind, expected.index, expected.count,
				$sformatf("actual id %0d kind %0d index %0d count %0d",
				actual.cu_id, actual.kind, actual.index, actual.count));
		end
	endtask

	task automatic check_count(input string name, input count_t expected,
		input count_t actual);
		if (actual !== expected) begin
			count_errors++;
			$display("error %s: expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("%s", msg);
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Chunks of CHUNK_SIZE items, then the remainder
	task automatic queue_expected(input cu_id_t owner, input count_t total);
		count_t    idx;
		count_t    left;
		read_cmd_t c;
		idx = '0;
		while (idx < total) begin
			left    = total - idx;
			c.cu_id = owner;
			if (owner == CU_VERTEX)
				c.kind = READ_VERTEX;
			else
				c.kind = READ_EDGE;
			c.index = idx;
			c.count = (left > CHUNK_SIZE) ? chunk_t'(CHUNK_SIZE) : chunk_t'(left);
			if (owner == CU_VERTEX)
				exp_vertex.push_back(c);
			else
				exp_edge.push_back(c);
			idx += count_t'(c.count);
		end
	endtask

	function automatic int commands_for(input count_t total);
		return int'((total + CHUNK_SIZE - 1) / CHUNK_SIZE);
	endfunction

	//////////////////////////////////////////////////
	// Monitor and memory model
	//////////////////////////////////////////////////

	task automatic watch_outputs();
		read_cmd_t act;
		if (enabled_in)
			low_cycles = 0;
		else
			low_cycles++;
		if (read_cmd_valid) begin
			act.cu_id = read_cmd_cu_id;
			act.kind  = read_cmd_kind;
			act.index = read_cmd_index;
			act.count = read_cmd_count;
			if (low_cycles >= 3)
				report_failure("A read command appeared while the unit was disabled");
			if (act.cu_id == CU_VERTEX) begin
				vertex_items += count_t'(act.count);
				if (exp_vertex.size() == 0)
					report_failure("A vertex command arrived when none was expected");
				else
					check_cmd("vertex command", exp_vertex.pop_front(), act);
			end else begin
				edge_items += count_t'(act.count);
				if (exp_edge.size() == 0)
					report_failure("An edge command arrived when none was expected");
				else
					check_cmd("edge command", exp_edge.pop_front(), act);
			end
			pend_due.push_back(cycle + int'($urandom_range(6, 1)));
			pend_id.push_back(act.cu_id);
			pend_cnt.push_back(act.count);
		end
		if (job_running && cu_done) begin
			if (pend_due.size() != 0 || exp_vertex.size() != 0 || exp_edge.size() != 0)
				report_failure("cu_done rose before every response had returned");
			done_seen = 1'b1;
		end
	endtask

	task automatic drive_memory();
		int ready [$];
		int pick;
		int i;
		read_rsp_valid = 1'b0;
		// Hold responses while the unit is disabled
		if (enabled_in) begin
			for (i = 0; i < pend_due.size(); i++) begin
				if (pend_due[i] <= cycle)
					ready.push_back(i);
			end
			if (ready.size() != 0) begin
				pick           = ready[$urandom_range(ready.size() - 1)];
				read_rsp_valid = 1'b1;
				read_rsp_cu_id = pend_id[pick];
				read_rsp_count = pend_cnt[pick];
				pend_due.delete(pick);
				pend_id.delete(pick);
				pend_cnt.delete(pick);
			end
		end
		read_alfull = ($urandom_range(99) < 30);
	endtask

	task automatic tick();
		@(negedge clock);
		cycle++;
		watch_outputs();
		drive_memory();
	endtask

	//////////////////////////////////////////////////
	// Jobs
	//////////////////////////////////////////////////

	task automatic run_job(input count_t nv, input count_t ne, input bit pause);
		int ticks;
		int pause_at;
		int pause_len;
		queue_expected(CU_VERTEX, nv);
		queue_expected(CU_EDGE, ne);
		vertex_items = '0;
		edge_items   = '0;
		done_seen    = 1'b0;
		pause_at     = $urandom_range(12, 3);
		pause_len    = $urandom_range(25, 5);
		ticks        = 0;
		num_vertices = nv;
		num_edges    = ne;
		start        = 1'b1;
		job_running  = 1'b1;
		tick();
		start = 1'b0;
		// Totals only count together with start
		num_vertices = $urandom;
		num_edges    = $urandom;
		if (cu_done)
			report_failure("cu_done was still high after a new start");
		while (!done_seen) begin
			if (pause && ticks == pause_at)
				enabled_in = 1'b0;
			if (pause && ticks == pause_at + pause_len)
				enabled_in = 1'b1;
			tick();
			ticks++;
		end
		enabled_in  = 1'b1;
		job_running = 1'b0;
		check_count("cu_return", nv, cu_return);
		check_count("vertex items", nv, vertex_items);
		check_count("edge items", ne, edge_items);
		if (exp_vertex.size() != 0 || exp_edge.size() != 0)
			report_failure("Commands were missing when the job finished");
		repeat ($urandom_range(5, 2)) tick();
	endtask

	initial begin
		int j;
		int total_errors;
		void'($urandom(32'hdf1d_d850));
		rstn           = 1'b0;
		enabled_in     = 1'b0;
		start          = 1'b0;
		num_vertices   = '0;
		num_edges      = '0;
		read_alfull    = 1'b0;
		read_rsp_valid = 1'b0;
		read_rsp_cu_id = CU_VERTEX;
		read_rsp_count = '0;

		// Odd vertex total, then a zero-edge job, then a long job with a pause
		job_nv[0] = count_t'(16 * $urandom_range(6, 2) + $urandom_range(15, 1));
		job_ne[0] = count_t'($urandom_range(120, 1));
		job_nv[1] = count_t'($urandom_range(90, 1));
		job_ne[1] = '0;
		job_nv[2] = count_t'($urandom_range(200, 100));
		job_ne[2] = count_t'($urandom_range(200, 100));
		for (j = 3; j < NUM_JOBS; j++) begin
			job_nv[j] = count_t'($urandom_range(150, 1));
			job_ne[j] = count_t'($urandom_range(150, 0));
		end
		for (j = 0; j < NUM_JOBS; j++)
			cycle_limit += 200 + 20 * (commands_for(job_nv[j]) + commands_for(job_ne[j]));

		repeat (16) @(negedge clock);
		rstn       = 1'b1;
		enabled_in = 1'b1;
		repeat (4) tick();
		for (j = 0; j < NUM_JOBS; j++)
			run_job(job_nv[j], job_ne[j], j == 2);
		repeat (10) tick();

		total_errors = cmd_errors + count_errors + other_errors
			+ u_cu_control.u_cu_control_sva.failures;
		$display("Errors: %0d command, %0d count, %0d other, %0d assertion",
			cmd_errors, count_errors, other_errors,
			u_cu_control.u_cu_control_sva.failures);
		if (total_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
